// File: logic/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// Serial timing
//////////////////////////////////////////////////////////////////////

// Clocks in one bit time, kept small for simulation
`define UART_CLKS_PER_BIT 8

//////////////////////////////////////////////////////////////////////
// Register bus map
//////////////////////////////////////////////////////////////////////

`define UART_ADDR_DATA 8'hFA
`define UART_ADDR_STAT 8'hFB

`endif

// File: logic/uart_pkg.sv
package uart_pkg;

    //////////////////////////////////////////////////////////////////
    // Data types
    //////////////////////////////////////////////////////////////////

    typedef logic [7:0] byte_t;

    // Status register layout, rx_pending lands in bit 7
    typedef struct packed {
        logic       rx_pending;
        logic       tx_busy;
        logic [5:0] zero;
    } status_t;

    //////////////////////////////////////////////////////////////////
    // FSM states
    //////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        txs_idle,
        txs_start,
        txs_data,
        txs_stop
    } tx_state_t;

    typedef enum logic [1:0] {
        rxs_idle,
        rxs_start,
        rxs_data,
        rxs_stop
    } rx_state_t;

endpackage

// File: logic/uart_link_if.sv
`timescale 1ns/1ns

interface uart_link_if;

    // Transmit request, tx_begin is a level held until tx_busy
    uart_pkg::byte_t tx_data;
    logic            tx_begin;
    logic            tx_busy;

    // Receive side, rx_recv pulses once per good frame
    uart_pkg::byte_t rx_data;
    logic            rx_recv;

    modport host (
        output tx_data,
        output tx_begin,
        input  tx_busy,
        input  rx_data,
        input  rx_recv
    );

    modport core (
        input  tx_data,
        input  tx_begin,
        output tx_busy,
        output rx_data,
        output rx_recv
    );

endinterface

// File: logic/uart_tx.sv
`timescale 1ns/1ns

`include "uart_settings.svh"

module uart_tx (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t data,
    input  logic            begin_req,
    output logic            busy,
    output logic            tx
);

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int CW  = (CPB > 1) ? $clog2(CPB) : 1;

    uart_pkg::tx_state_t state;
    logic [CW-1:0]       cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shift;
    logic                bit_end;

    assign bit_end = (cnt == CW'(CPB - 1));

    // Busy drops on the last cycle of the stop bit
    assign busy = (state != uart_pkg::txs_idle) &&
                  !(state == uart_pkg::txs_stop && bit_end);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= uart_pkg::txs_idle;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
        end else begin
            case (state)
                uart_pkg::txs_idle: begin
                    cnt <= '0;
                    if (begin_req) begin
                        state <= uart_pkg::txs_start;
                        tx    <= 1'b0;
                    end
                end
                uart_pkg::txs_start: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= uart_pkg::txs_data;
                        tx      <= shift[0];
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_pkg::txs_data: begin
                    if (bit_end) begin
                        cnt <= '0;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::txs_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift[1];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    // Stop bit, line already high
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= uart_pkg::txs_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Byte latch on accept, then LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::txs_idle && begin_req) begin
            shift <= data;
        end else if (state == uart_pkg::txs_data && bit_end) begin
            shift <= shift >> 1;
        end
    end

    a_idle_line_high: assert property (
        @(posedge clk) disable iff (!rst_n)
        state == uart_pkg::txs_idle |-> tx
    );

endmodule

// File: logic/uart_rx.sv
`timescale 1ns/1ns

`include "uart_settings.svh"

module uart_rx (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            rx,
    output uart_pkg::byte_t data,
    output logic            recv
);

    localparam int CPB  = `UART_CLKS_PER_BIT;
    localparam int HALF = (CPB > 1) ? CPB / 2 : 1;
    localparam int CW   = (CPB > 1) ? $clog2(CPB) : 1;

    logic                rx_s1;
    logic                rx_s2;
    logic                rx_d;
    logic                fall;
    uart_pkg::rx_state_t state;
    logic [CW-1:0]       cnt;
    logic [2:0]          bit_idx;
    uart_pkg::byte_t     shift;
    logic                bit_end;
    logic                half_end;

    //////////////////////////////////////////////////////////////////
    // Synchronizer and edge detect
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_s1 <= 1'b1;
            rx_s2 <= 1'b1;
            rx_d  <= 1'b1;
        end else begin
            rx_s1 <= rx;
            rx_s2 <= rx_s1;
            rx_d  <= rx_s2;
        end
    end

    assign fall     = rx_d & ~rx_s2;
    assign bit_end  = (cnt == CW'(CPB - 1));
    assign half_end = (cnt == CW'(HALF - 1));

    //////////////////////////////////////////////////////////////////
    // Frame FSM
    //////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= uart_pkg::rxs_idle;
            cnt     <= '0;
            bit_idx <= '0;
            recv    <= 1'b0;
            data    <= '0;
        end else begin
            recv <= 1'b0;
            case (state)
                uart_pkg::rxs_idle: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= uart_pkg::rxs_start;
                    end
                end
                uart_pkg::rxs_start: begin
                    // Mid start bit, a high line here was a glitch
                    if (half_end) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_s2 ? uart_pkg::rxs_idle : uart_pkg::rxs_data;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                uart_pkg::rxs_data: begin
                    if (bit_end) begin
                        cnt     <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= uart_pkg::rxs_stop;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    if (bit_end) begin
                        cnt   <= '0;
                        state <= uart_pkg::rxs_idle;
                        // Low stop bit means the frame is dropped
                        if (rx_s2) begin
                            data <= shift;
                            recv <= 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
            endcase
        end
    end

    // Bits arrive LSB first
    always_ff @(posedge clk) begin
        if (state == uart_pkg::rxs_data && bit_end) begin
            shift <= {rx_s2, shift[7:1]};
        end
    end

    a_recv_single: assert property (
        @(posedge clk) disable iff (!rst_n)
        recv |=> !recv
    );

endmodule

// File: logic/uart_core.sv
`timescale 1ns/1ns

module uart_core (
    input  logic       clk,
    input  logic       rst_n,
    uart_link_if.core  link,
    output logic       tx,
    input  logic       rx
);

    uart_tx u_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .data      (link.tx_data),
        .begin_req (link.tx_begin),
        .busy      (link.tx_busy),
        .tx        (tx)
    );

    uart_rx u_rx (
        .clk   (clk),
        .rst_n (rst_n),
        .rx    (rx),
        .data  (link.rx_data),
        .recv  (link.rx_recv)
    );

    // Host may read rx_data at any time between frames
    a_rx_data_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        !link.rx_recv |-> $stable(link.rx_data)
    );

endmodule

// File: logic/uart_regport.sv
`timescale 1ns/1ns

`include "uart_settings.svh"

module uart_regport (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t addr,
    input  uart_pkg::byte_t din,
    input  logic            regrd,
    input  logic            regwr,
    output uart_pkg::byte_t dout,
    output logic            oe_n,
    uart_link_if.host       link
);

    logic              sel_data;
    logic              sel_stat;
    logic              wr_strobe;
    logic              wr_hold;
    logic              wr_start;
    logic              stat_rd;
    logic              stat_active;
    logic              rx_pending;
    logic              tx_begin;
    uart_pkg::byte_t   tx_data;
    uart_pkg::status_t status;

    assign sel_data = (addr == `UART_ADDR_DATA);
    assign sel_stat = (addr == `UART_ADDR_STAT);
    assign stat_rd  = regrd && sel_stat;

    //////////////////////////////////////////////////////////////////
    // Read side
    //////////////////////////////////////////////////////////////////

    always_comb begin
        status            = '0;
        status.rx_pending = rx_pending;
        status.tx_busy    = link.tx_busy;
    end

    always_comb begin
        dout = '0;
        oe_n = 1'b1;
        if (regrd && sel_data) begin
            dout = link.rx_data;
            oe_n = 1'b0;
        end else if (stat_rd) begin
            dout = status;
            oe_n = 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////
    // Write side
    //////////////////////////////////////////////////////////////////

    // One start per strobe assertion, dropped while busy
    assign wr_strobe = regwr && sel_data;
    assign wr_start  = wr_strobe && !wr_hold && !tx_begin && !link.tx_busy;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_hold  <= 1'b0;
            tx_begin <= 1'b0;
        end else begin
            wr_hold <= wr_strobe;
            if (wr_start) begin
                tx_begin <= 1'b1;
            end else if (link.tx_busy) begin
                tx_begin <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_start) begin
            tx_data <= din;
        end
    end

    assign link.tx_begin = tx_begin;
    assign link.tx_data  = tx_data;

    // Sticky pending flag, cleared once a status read has ended
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_pending  <= 1'b0;
            stat_active <= 1'b0;
        end else if (link.rx_recv) begin
            // A new byte outlives any status read already finished
            rx_pending  <= 1'b1;
            stat_active <= 1'b0;
        end else if (stat_rd) begin
            stat_active <= 1'b1;
        end else if (stat_active) begin
            stat_active <= 1'b0;
            rx_pending  <= 1'b0;
        end
    end

    a_begin_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(link.tx_begin) |-> !link.tx_busy
    );

    // Pending only falls on the cycle after a status read ends
    a_pending_clear_after_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(rx_pending) |-> $past(stat_rd, 2)
    );

endmodule

// File: logic/uart_periph.sv
`timescale 1ns/1ns

module uart_periph (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t addr,
    input  logic            regrd,
    input  logic            regwr,
    input  uart_pkg::byte_t din,
    output uart_pkg::byte_t dout,
    output logic            oe_n,
    output logic            uart_tx,
    input  logic            uart_rx
);

    uart_link_if link ();

    // CPU register bus side
    uart_regport u_regport (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .din   (din),
        .regrd (regrd),
        .regwr (regwr),
        .dout  (dout),
        .oe_n  (oe_n),
        .link  (link.host)
    );

    // Serial line side
    uart_core u_core (
        .clk   (clk),
        .rst_n (rst_n),
        .link  (link.core),
        .tx    (uart_tx),
        .rx    (uart_rx)
    );

endmodule

// File: tests/uart_checker.sv
`timescale 1ns/1ns

`include "uart_settings.svh"

module uart_checker (
    input  logic            clk,
    input  logic            rst_n,
    input  uart_pkg::byte_t addr,
    input  logic            regrd,
    input  uart_pkg::byte_t dout,
    input  logic            oe_n,
    input  logic            uart_tx
);

    localparam int CPB = `UART_CLKS_PER_BIT;

    uart_pkg::byte_t frame_q[$];
    uart_pkg::byte_t exp_dout;
    logic            exp_oe;
    logic            left_reset = 1'b0;
    int              value_errs = 0;
    int              frame_errs = 0;

    task automatic expect_read(input uart_pkg::byte_t d, input logic oe);
        exp_dout = d;
        exp_oe   = oe;
    endtask

    task automatic expect_frame(input uart_pkg::byte_t b);
        frame_q.push_back(b);
    endtask

    task automatic report_mismatch(input string name, input logic [7:0] exp,
                                   input logic [7:0] act);
        value_errs++;
        $display("ERR t=%0t %s expected %h got %h", $time, name, exp, act);
    endtask

    task automatic finish_check();
        if (frame_q.size() != 0) begin
            frame_errs += frame_q.size();
            $display("Missing %0d expected frame(s) on uart_tx", frame_q.size());
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Bus read side
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : read_check
        uart_pkg::status_t st;
        st = dout;
        if (rst_n && !left_reset) begin
            left_reset = 1'b1;
            if (uart_tx !== 1'b1) begin
                frame_errs++;
                $display("uart_tx line is not idle high after reset at %0t", $time);
            end
        end
        if (rst_n && regrd) begin
            if (dout !== exp_dout) begin
                report_mismatch("dout", exp_dout, dout);
                if (addr == `UART_ADDR_STAT) begin
                    $display("  status read rx_pending=%b tx_busy=%b",
                             st.rx_pending, st.tx_busy);
                end
            end
            if (oe_n !== exp_oe) begin
                report_mismatch("oe_n", exp_oe, oe_n);
            end
        end else if (rst_n) begin
            // No read selected
            if (dout !== 8'h00) begin
                report_mismatch("dout", 8'h00, dout);
            end
            if (oe_n !== 1'b1) begin
                report_mismatch("oe_n", 1'b1, oe_n);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Independent 8N1 decoder on uart_tx
    //////////////////////////////////////////////////////////////////////

    initial begin : tx_decode
        uart_pkg::byte_t b;
        uart_pkg::byte_t exp;
        int              i;
        forever begin
            @(posedge clk);
            if (rst_n && uart_tx === 1'b0) begin
                // Now at the first sample of the start bit
                repeat (CPB / 2) @(posedge clk);
                if (uart_tx !== 1'b0) begin
                    frame_errs++;
                    $display("Start bit on uart_tx did not last to mid-bit at %0t", $time);
                end else begin
                    for (i = 0; i < 8; i++) begin
                        repeat (CPB) @(posedge clk);
                        b[i] = uart_tx;
                    end
                    repeat (CPB) @(posedge clk);
                    if (uart_tx !== 1'b1) begin
                        frame_errs++;
                        $display("Frame on uart_tx has a low stop bit at %0t", $time);
                    end else if (frame_q.size() == 0) begin
                        frame_errs++;
                        $display("Unexpected frame %h on uart_tx at %0t", b, $time);
                    end else begin
                        exp = frame_q.pop_front();
                        if (b !== exp) begin
                            report_mismatch("uart_tx", exp, b);
                        end
                    end
                end
            end
        end
    end

endmodule

// File: tests/tb_uart_periph.sv
`timescale 1ns/1ns

`include "uart_settings.svh"

module tb_uart_periph;

    localparam int CPB    = `UART_CLKS_PER_BIT;
    localparam int PERIOD = 4;

    logic            clk;
    logic            rst_n;
    uart_pkg::byte_t addr;
    logic            regrd;
    logic            regwr;
    uart_pkg::byte_t din;
    uart_pkg::byte_t dout;
    logic            oe_n;
    logic            uart_tx;
    logic            uart_rx;

    string           lines[$];
    logic            loaded = 1'b0;
    int              script_errs = 0;

    uart_periph UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .regrd   (regrd),
        .regwr   (regwr),
        .din     (din),
        .dout    (dout),
        .oe_n    (oe_n),
        .uart_tx (uart_tx),
        .uart_rx (uart_rx)
    );

    uart_checker chk (
        .clk     (clk),
        .rst_n   (rst_n),
        .addr    (addr),
        .regrd   (regrd),
        .dout    (dout),
        .oe_n    (oe_n),
        .uart_tx (uart_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Bus and serial drivers, all on the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic bus_write(input uart_pkg::byte_t a, input uart_pkg::byte_t d);
        @(negedge clk);
        addr  = a;
        din   = d;
        regwr = 1'b1;
        @(negedge clk);
        regwr = 1'b0;
    endtask

    task automatic bus_read(input uart_pkg::byte_t a, input uart_pkg::byte_t d,
                            input logic oe);
        @(negedge clk);
        chk.expect_read(d, oe);
        addr  = a;
        regrd = 1'b1;
        @(negedge clk);
        regrd = 1'b0;
    endtask

    task automatic send_serial(input uart_pkg::byte_t b, input logic stop);
        int i;
        @(negedge clk);
        uart_rx = 1'b0;
        repeat (CPB) @(negedge clk);
        for (i = 0; i < 8; i++) begin
            uart_rx = b[i];
            repeat (CPB) @(negedge clk);
        end
        uart_rx = stop;
        repeat (CPB) @(negedge clk);
        uart_rx = 1'b1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        int          fd;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        rst_n   = 1'b0;
        addr    = '0;
        din     = '0;
        regrd   = 1'b0;
        regwr   = 1'b0;
        uart_rx = 1'b1;
        fd = $fopen("tests/uart_golden.txt", "r");
        if (fd == 0) begin
            script_errs++;
            $display("Cannot open golden file tests/uart_golden.txt");
        end else begin
            while ($fgets(line, fd)) begin
                // Comment and blank lines are skipped
                if (line.len() > 1 && line[0] != "#") begin
                    lines.push_back(line);
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (lines[n]) begin
            a = '0;
            b = '0;
            c = '0;
            void'($sscanf(lines[n], "%c %h %h %h", op, a, b, c));
            case (op)
                "W": bus_write(a[7:0], b[7:0]);
                "R": bus_read(a[7:0], b[7:0], c[0]);
                "S": send_serial(a[7:0], b[0]);
                "E": chk.expect_frame(a[7:0]);
                "I": repeat (a) @(negedge clk);
                default: begin
                    script_errs++;
                    $display("Unknown opcode in golden line %0d", n + 1);
                end
            endcase
        end
        repeat (4) @(negedge clk);
        chk.finish_check();
        $display("errors: value %0d, frame %0d, script %0d",
                 chk.value_errs, chk.frame_errs, script_errs);
        if (chk.value_errs + chk.frame_errs + script_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Watchdog, 12 bit times per golden line
    initial begin : watchdog
        longint limit_ns;
        wait (loaded);
        limit_ns = (lines.size() + 2) * 12 * CPB * PERIOD;
        #(limit_ns);
        $display("Timeout after %0d ns, the run did not finish", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

endmodule

// File: tests/uart_golden.txt
# op addr/byte  data/stop  oe_n   all numbers hex
# W addr data | R addr dout oe_n | S byte stop | E byte | I cycles
R 00 00 1
R FA 00 0
E A5
W FA A5
I 04
R FB 40 0
W FA 3C
I 60
R FB 00 0
E 3C
W FA 3C
I 60
E 01
W FA 01
I 60
S 5A 1
I 14
R FA 5A 0
R FA 5A 0
R FB 80 0
R FB 00 0
S C3 0
I 14
R FB 00 0
R FA 5A 0
R 10 00 1

// File: filelist.f
+incdir+logic
logic/uart_pkg.sv
logic/uart_link_if.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_core.sv
logic/uart_regport.sv
logic/uart_periph.sv
tests/uart_checker.sv
tests/tb_uart_periph.sv

// File: Bender.yml
package:
  name: uart_periph

sources:
  - include_dirs:
      - logic
    files:
      - logic/uart_pkg.sv
      - logic/uart_link_if.sv
      - logic/uart_tx.sv
      - logic/uart_rx.sv
      - logic/uart_core.sv
      - logic/uart_regport.sv
      - logic/uart_periph.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/uart_checker.sv
      - tests/tb_uart_periph.sv
